//--- include/id_defs.svh
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

// Datapath word, also the PC width
`define XLEN 16

// Register file depth
`define NREGS 16

// Bits needed to name one register
`define REG_AW 4

`endif

//--- hw/isa_pkg.sv
`include "id_defs.svh"

package isa_pkg;

	//////////////////////////////
	// Opcodes
	//////////////////////////////

	// Top nibble of every instruction
	typedef enum logic [3:0] {
		OP_NOP  = 4'h0,
		OP_ADD  = 4'h1,
		OP_SUB  = 4'h2,
		OP_AND  = 4'h3,
		OP_OR   = 4'h4,
		OP_XOR  = 4'h5,
		OP_SLL  = 4'h6,
		OP_SRL  = 4'h7,
		// I-format, 8-bit immediate
		OP_ADDI = 4'h8,
		OP_LUI  = 4'h9,
		// R-format, rt field is the offset
		OP_LW   = 4'ha,
		OP_SW   = 4'hb,
		// I-format, signed PC offset
		OP_B    = 4'hc,
		OP_BEQZ = 4'hd,
		OP_BNEZ = 4'he,
		// Jump to rs
		OP_JR   = 4'hf
	} opcode_e;

	// Operation handed to the execute stage
	typedef enum logic [2:0] {
		ALU_ADD   = 3'd0,
		ALU_SUB   = 3'd1,
		ALU_AND   = 3'd2,
		ALU_OR    = 3'd3,
		ALU_XOR   = 3'd4,
		ALU_SLL   = 3'd5,
		ALU_SRL   = 3'd6,
		ALU_PASSB = 3'd7
	} alu_op_e;

	//////////////////////////////
	// Instruction views
	//////////////////////////////

	// Three register fields
	typedef struct packed {
		opcode_e                opcode;
		logic [`REG_AW-1:0]     rd;
		logic [`REG_AW-1:0]     rs;
		logic [`REG_AW-1:0]     rt;
	} instr_r_t;

	// One register plus an immediate byte
	typedef struct packed {
		opcode_e                opcode;
		logic [`REG_AW-1:0]     rd;
		logic [7:0]             imm8;
	} instr_i_t;

	// Same word, two readings picked by opcode
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

endpackage

//--- hw/pipe_pkg.sv
`include "id_defs.svh"

package pipe_pkg;

	// Second ALU operand source
	typedef enum logic [1:0] {
		SRC_RT       = 2'd0,
		SRC_SIMM8    = 2'd1,
		SRC_ZIMM8_HI = 2'd2,
		SRC_SIMM4    = 2'd3
	} src_b_e;

	// Branch condition, tested on register A
	typedef enum logic [1:0] {
		BR_ALWAYS = 2'd0,
		BR_EQZ    = 2'd1,
		BR_NEZ    = 2'd2
	} br_cond_e;

	// Control word out of the decoder
	typedef struct packed {
		logic               reg_write;
		logic               mem_to_reg;
		logic               mem_read;
		logic               mem_write;
		isa_pkg::alu_op_e   alu_op;
		src_b_e             src_b;
		logic               is_branch;
		logic               is_jump;
		br_cond_e           br_cond;
	} ctrl_t;

	// Everything the execute stage needs
	typedef struct packed {
		logic                   valid;
		ctrl_t                  ctrl;
		logic [`XLEN-1:0]       alu_a;
		logic [`XLEN-1:0]       alu_b;
		logic [`XLEN-1:0]       mem_data;
		logic [`REG_AW-1:0]     rd;
		logic [`REG_AW-1:0]     rs;
		logic [`REG_AW-1:0]     rt;
	} id_ex_t;

	// Redirect request back to fetch
	typedef struct packed {
		logic               redirect;
		logic               is_branch;
		logic               is_jump;
		logic [`XLEN-1:0]   target;
	} branch_t;

	// Register write from the writeback stage
	typedef struct packed {
		logic                   we;
		logic [`REG_AW-1:0]     addr;
		logic [`XLEN-1:0]       data;
	} wb_t;

endpackage

//--- hw/id_decoder.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module id_decoder (
	input  isa_pkg::instr_u         instr_i,
	output logic [`REG_AW-1:0]      raddr_a_o,
	output logic [`REG_AW-1:0]      raddr_b_o,
	output logic [`XLEN-1:0]        imm_o,
	output pipe_pkg::ctrl_t         ctrl_o,
	output logic [`REG_AW-1:0]      rd_o,
	output logic [`REG_AW-1:0]      rs_o,
	output logic [`REG_AW-1:0]      rt_o
);

	// Sign-extended immediates of both formats
	logic [`XLEN-1:0] simm8;
	logic [`XLEN-1:0] simm4;

	assign simm8 = {{(`XLEN-8){instr_i.i.imm8[7]}}, instr_i.i.imm8};
	assign simm4 = {{(`XLEN-`REG_AW){instr_i.r.rt[`REG_AW-1]}}, instr_i.r.rt};

	//////////////////////////////
	// Main decode
	//////////////////////////////

	// rs_o / rt_o name only the registers really consumed, zero otherwise
	always_comb begin
		// Defaults give a NOP
		ctrl_o    = '0;
		raddr_a_o = instr_i.r.rs;
		raddr_b_o = instr_i.r.rt;
		imm_o     = simm8;
		rd_o      = '0;
		rs_o      = '0;
		rt_o      = '0;

		case (instr_i.r.opcode)
			isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND, isa_pkg::OP_OR,
			isa_pkg::OP_XOR, isa_pkg::OP_SLL, isa_pkg::OP_SRL: begin
				ctrl_o.reg_write = 1'b1;
				ctrl_o.src_b     = pipe_pkg::SRC_RT;
				rd_o             = instr_i.r.rd;
				rs_o             = instr_i.r.rs;
				rt_o             = instr_i.r.rt;
				// Opcode to ALU op
				case (instr_i.r.opcode)
					isa_pkg::OP_SUB: ctrl_o.alu_op = isa_pkg::ALU_SUB;
					isa_pkg::OP_AND: ctrl_o.alu_op = isa_pkg::ALU_AND;
					isa_pkg::OP_OR:  ctrl_o.alu_op = isa_pkg::ALU_OR;
					isa_pkg::OP_XOR: ctrl_o.alu_op = isa_pkg::ALU_XOR;
					isa_pkg::OP_SLL: ctrl_o.alu_op = isa_pkg::ALU_SLL;
					isa_pkg::OP_SRL: ctrl_o.alu_op = isa_pkg::ALU_SRL;
					default:         ctrl_o.alu_op = isa_pkg::ALU_ADD;
				endcase
			end
			// rd = rd + simm8
			isa_pkg::OP_ADDI: begin
				ctrl_o.reg_write = 1'b1;
				ctrl_o.alu_op    = isa_pkg::ALU_ADD;
				ctrl_o.src_b     = pipe_pkg::SRC_SIMM8;
				raddr_a_o        = instr_i.i.rd;
				rd_o             = instr_i.i.rd;
				rs_o             = instr_i.i.rd;
			end
			// rd = imm8 << 8, no register source
			isa_pkg::OP_LUI: begin
				ctrl_o.reg_write = 1'b1;
				ctrl_o.alu_op    = isa_pkg::ALU_PASSB;
				ctrl_o.src_b     = pipe_pkg::SRC_ZIMM8_HI;
				raddr_a_o        = instr_i.i.rd;
				rd_o             = instr_i.i.rd;
			end
			// rd = mem[rs + simm4]
			isa_pkg::OP_LW: begin
				ctrl_o.reg_write  = 1'b1;
				ctrl_o.mem_to_reg = 1'b1;
				ctrl_o.mem_read   = 1'b1;
				ctrl_o.alu_op     = isa_pkg::ALU_ADD;
				ctrl_o.src_b      = pipe_pkg::SRC_SIMM4;
				imm_o             = simm4;
				rd_o              = instr_i.r.rd;
				rs_o              = instr_i.r.rs;
			end
			// mem[rs + simm4] = rd, store data on port B
			isa_pkg::OP_SW: begin
				ctrl_o.mem_write = 1'b1;
				ctrl_o.alu_op    = isa_pkg::ALU_ADD;
				ctrl_o.src_b     = pipe_pkg::SRC_SIMM4;
				raddr_b_o        = instr_i.r.rd;
				imm_o            = simm4;
				rs_o             = instr_i.r.rs;
				rt_o             = instr_i.r.rd;
			end
			// Branches test rd on port A
			isa_pkg::OP_B, isa_pkg::OP_BEQZ, isa_pkg::OP_BNEZ: begin
				ctrl_o.is_branch = 1'b1;
				raddr_a_o        = instr_i.i.rd;
				if (instr_i.i.opcode == isa_pkg::OP_BEQZ) begin
					ctrl_o.br_cond = pipe_pkg::BR_EQZ;
					rs_o           = instr_i.i.rd;
				end else if (instr_i.i.opcode == isa_pkg::OP_BNEZ) begin
					ctrl_o.br_cond = pipe_pkg::BR_NEZ;
					rs_o           = instr_i.i.rd;
				end else begin
					ctrl_o.br_cond = pipe_pkg::BR_ALWAYS;
				end
			end
			// Target comes from rs
			isa_pkg::OP_JR: begin
				ctrl_o.is_jump = 1'b1;
				rs_o           = instr_i.r.rs;
			end
			default: begin
				ctrl_o = '0;
			end
		endcase
	end

endmodule

//--- hw/id_reg_file.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module id_reg_file (
	input  logic                    clk_i,
	input  logic                    arst_n_i,
	input  logic [`REG_AW-1:0]      raddr_a_i,
	input  logic [`REG_AW-1:0]      raddr_b_i,
	input  pipe_pkg::wb_t           wb_i,
	output logic [`XLEN-1:0]        rdata_a_o,
	output logic [`XLEN-1:0]        rdata_b_o
);

	logic [`XLEN-1:0] regs [`NREGS];

	// Both read ports handled by one loop
	logic [`REG_AW-1:0] raddr [2];
	logic [`XLEN-1:0]   rdata [2];

	//////////////////////////////
	// Write port
	//////////////////////////////

	// Writes to r0 dropped
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < `NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_i.we && (wb_i.addr != '0)) begin
			regs[wb_i.addr] <= wb_i.data;
		end
	end

	//////////////////////////////
	// Read ports
	//////////////////////////////

	assign raddr[0] = raddr_a_i;
	assign raddr[1] = raddr_b_i;

	for (genvar p = 0; p < 2; p++) begin : g_rd
		always_comb begin
			if (raddr[p] == '0) begin
				rdata[p] = '0;
			end else if (wb_i.we && (wb_i.addr == raddr[p])) begin
				// Write-through of same-cycle writeback
				rdata[p] = wb_i.data;
			end else begin
				rdata[p] = regs[raddr[p]];
			end
		end
	end

	assign rdata_a_o = rdata[0];
	assign rdata_b_o = rdata[1];

endmodule

//--- hw/id_operand_sel.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module id_operand_sel (
	input  logic [`XLEN-1:0]        rdata_a_i,
	input  logic [`XLEN-1:0]        rdata_b_i,
	input  logic [`XLEN-1:0]        imm_i,
	input  pipe_pkg::src_b_e        src_b_i,
	output logic [`XLEN-1:0]        alu_a_o,
	output logic [`XLEN-1:0]        alu_b_o,
	output logic [`XLEN-1:0]        mem_data_o
);

	// Immediate shapes from the low bits
	logic [`XLEN-1:0] simm8;
	logic [`XLEN-1:0] zimm8_hi;
	logic [`XLEN-1:0] simm4;

	assign simm8    = {{(`XLEN-8){imm_i[7]}}, imm_i[7:0]};
	assign zimm8_hi = {imm_i[7:0], {(`XLEN-8){1'b0}}};
	assign simm4    = {{(`XLEN-4){imm_i[3]}}, imm_i[3:0]};

	// Port A always feeds the first operand
	assign alu_a_o = rdata_a_i;

	always_comb begin
		case (src_b_i)
			pipe_pkg::SRC_SIMM8:    alu_b_o = simm8;
			// LUI
			pipe_pkg::SRC_ZIMM8_HI: alu_b_o = zimm8_hi;
			// LW / SW offset
			pipe_pkg::SRC_SIMM4:    alu_b_o = simm4;
			default:                alu_b_o = rdata_b_i;
		endcase
	end

	// Store data rides port B
	assign mem_data_o = rdata_b_i;

endmodule

//--- hw/id_branch_unit.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module id_branch_unit (
	input  pipe_pkg::ctrl_t         ctrl_i,
	input  logic [`XLEN-1:0]        rdata_a_i,
	input  logic [`XLEN-1:0]        imm_i,
	input  logic [`XLEN-1:0]        pcplus1_i,
	output pipe_pkg::branch_t       branch_o
);

	logic is_zero;
	logic cond_ok;

	assign is_zero = (rdata_a_i == '0);

	// Condition on register A
	always_comb begin
		case (ctrl_i.br_cond)
			pipe_pkg::BR_ALWAYS: cond_ok = 1'b1;
			pipe_pkg::BR_EQZ:    cond_ok = is_zero;
			pipe_pkg::BR_NEZ:    cond_ok = !is_zero;
			default:             cond_ok = 1'b0;
		endcase
	end

	assign branch_o.redirect  = (ctrl_i.is_branch && cond_ok) || ctrl_i.is_jump;
	assign branch_o.is_branch = ctrl_i.is_branch;
	assign branch_o.is_jump   = ctrl_i.is_jump;
	// JR uses the register, branches are PC relative
	assign branch_o.target    = ctrl_i.is_jump ? rdata_a_i : (pcplus1_i + imm_i);

endmodule

//--- hw/id_ex_reg.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module id_ex_reg (
	input  logic                    clk_i,
	input  logic                    arst_n_i,
	input  logic                    stall_i,
	input  logic                    flush_i,
	input  pipe_pkg::id_ex_t        d_i,
	output pipe_pkg::id_ex_t        q_o
);

	//////////////////////////////
	// Pipeline register
	//////////////////////////////

	// Bubble is the all-zero bundle
	// Flush beats stall
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			q_o <= '0;
		end else if (flush_i) begin
			q_o <= '0;
		end else if (!stall_i) begin
			q_o <= d_i;
		end
	end

endmodule

//--- hw/id_stage.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module id_stage (
	input  logic                    clk_i,
	input  logic                    arst_n_i,
	input  isa_pkg::instr_u         instr_i,
	input  logic [`XLEN-1:0]        pcplus1_i,
	input  logic                    stall_i,
	input  logic                    flush_i,
	input  pipe_pkg::wb_t           wb_i,
	output pipe_pkg::id_ex_t        id_ex_o,
	output pipe_pkg::branch_t       branch_o
);

	// Decoder outputs
	logic [`REG_AW-1:0]  raddr_a;
	logic [`REG_AW-1:0]  raddr_b;
	logic [`XLEN-1:0]    imm;
	pipe_pkg::ctrl_t     ctrl;
	logic [`REG_AW-1:0]  rd;
	logic [`REG_AW-1:0]  rs;
	logic [`REG_AW-1:0]  rt;

	// Register file and operand paths
	logic [`XLEN-1:0]    rdata_a;
	logic [`XLEN-1:0]    rdata_b;
	logic [`XLEN-1:0]    alu_a;
	logic [`XLEN-1:0]    alu_b;
	logic [`XLEN-1:0]    mem_data;

	pipe_pkg::id_ex_t    id_ex_d;

	//////////////////////////////
	// Decode and operand read
	//////////////////////////////

	id_decoder u_decoder (
		.instr_i   (instr_i),
		.raddr_a_o (raddr_a),
		.raddr_b_o (raddr_b),
		.imm_o     (imm),
		.ctrl_o    (ctrl),
		.rd_o      (rd),
		.rs_o      (rs),
		.rt_o      (rt)
	);

	id_reg_file u_reg_file (
		.clk_i     (clk_i),
		.arst_n_i  (arst_n_i),
		.raddr_a_i (raddr_a),
		.raddr_b_i (raddr_b),
		.wb_i      (wb_i),
		.rdata_a_o (rdata_a),
		.rdata_b_o (rdata_b)
	);

	id_operand_sel u_operand_sel (
		.rdata_a_i  (rdata_a),
		.rdata_b_i  (rdata_b),
		.imm_i      (imm),
		.src_b_i    (ctrl.src_b),
		.alu_a_o    (alu_a),
		.alu_b_o    (alu_b),
		.mem_data_o (mem_data)
	);

	// Same-cycle redirect to fetch
	id_branch_unit u_branch_unit (
		.ctrl_i    (ctrl),
		.rdata_a_i (rdata_a),
		.imm_i     (imm),
		.pcplus1_i (pcplus1_i),
		.branch_o  (branch_o)
	);

	//////////////////////////////
	// ID/EX latch
	//////////////////////////////

	// Every decoded slot is valid, bubbles come only from flush
	assign id_ex_d = '{
		valid:    1'b1,
		ctrl:     ctrl,
		alu_a:    alu_a,
		alu_b:    alu_b,
		mem_data: mem_data,
		rd:       rd,
		rs:       rs,
		rt:       rt
	};

	id_ex_reg u_id_ex_reg (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.stall_i  (stall_i),
		.flush_i  (flush_i),
		.d_i      (id_ex_d),
		.q_o      (id_ex_o)
	);

endmodule

//--- test/tb_id_stage.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module tb_id_stage;

	// Cycle budget of each test
	localparam int RESET_CYCLES = 16;
	localparam int N_WRITE      = 16;
	localparam int N_RREAD      = 32;
	localparam int N_MEM        = 40;
	localparam int N_BRANCH     = 48;
	localparam int N_STALL      = 48;
	localparam int N_FWD        = 32;
	localparam int SETTLE       = 2;
	localparam int TOTAL_CYCLES = 1 + N_WRITE + N_RREAD + N_MEM + N_BRANCH + N_STALL + N_FWD
		+ 5 * SETTLE;
	localparam int CYCLE_LIMIT  = 2 * TOTAL_CYCLES + RESET_CYCLES;

	logic                clk_i;
	logic                arst_n_i;
	isa_pkg::instr_u     instr;
	logic [`XLEN-1:0]    pcplus1;
	logic                stall;
	logic                flush;
	pipe_pkg::wb_t       wb;
	pipe_pkg::id_ex_t    id_ex;
	pipe_pkg::branch_t   branch;

	// Shadow of the register file
	logic [`XLEN-1:0]    shadow [`NREGS];
	pipe_pkg::id_ex_t    exp_q;
	logic [31:0]         rng;
	int                  errors = 0;
	int                  checks = 0;
	int                  tests  = 0;
	int                  cycles = 0;

	id_stage uut (
		.clk_i     (clk_i),
		.arst_n_i  (arst_n_i),
		.instr_i   (instr),
		.pcplus1_i (pcplus1),
		.stall_i   (stall),
		.flush_i   (flush),
		.wb_i      (wb),
		.id_ex_o   (id_ex),
		.branch_o  (branch)
	);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	////////////////////////////////
	// Stimulus helpers
	////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// Random fields under a fixed opcode
	function automatic isa_pkg::instr_u make_instr(input logic [3:0] op);
		isa_pkg::instr_u ins;
		logic [31:0]     r;
		r = next_rand();
		ins = r[15:0];
		ins.r.opcode = isa_pkg::opcode_e'(op);
		return ins;
	endfunction

	function automatic pipe_pkg::wb_t make_wb(input logic we, input logic [`REG_AW-1:0] addr,
			input logic [`XLEN-1:0] data);
		pipe_pkg::wb_t w;
		w.we   = we;
		w.addr = addr;
		w.data = data;
		return w;
	endfunction

	task automatic apply_inputs(input isa_pkg::instr_u ins, input logic [`XLEN-1:0] pc,
			input logic st, input logic fl, input pipe_pkg::wb_t w);
		@(posedge clk_i);
		instr   <= ins;
		pcplus1 <= pc;
		stall   <= st;
		flush   <= fl;
		wb      <= w;
	endtask

	////////////////////////////////
	// Reference model
	////////////////////////////////

	// Zero register and same-cycle write-through
	function automatic logic [`XLEN-1:0] reg_read(input logic [`REG_AW-1:0] a,
			input pipe_pkg::wb_t w);
		if (a == '0)
			return '0;
		if (w.we && (w.addr == a))
			return w.data;
		return shadow[a];
	endfunction

	function automatic void ref_decode(input isa_pkg::instr_u ins, input logic [`XLEN-1:0] pc,
			input pipe_pkg::wb_t w, output pipe_pkg::id_ex_t ex, output pipe_pkg::branch_t br);
		logic [`REG_AW-1:0] ra;
		logic [`REG_AW-1:0] rb;
		logic [`XLEN-1:0]   va;
		logic [`XLEN-1:0]   vb;
		logic [`XLEN-1:0]   s8;
		logic [`XLEN-1:0]   s4;
		ex = '0;
		br = '0;
		ex.valid = 1'b1;
		ra = ins.r.rs;
		rb = ins.r.rt;
		s8 = `XLEN'($signed(ins.i.imm8));
		s4 = `XLEN'($signed(ins.r.rt));
		case (ins.r.opcode)
			isa_pkg::OP_ADD: ex.ctrl.alu_op = isa_pkg::ALU_ADD;
			isa_pkg::OP_SUB: ex.ctrl.alu_op = isa_pkg::ALU_SUB;
			isa_pkg::OP_AND: ex.ctrl.alu_op = isa_pkg::ALU_AND;
			isa_pkg::OP_OR:  ex.ctrl.alu_op = isa_pkg::ALU_OR;
			isa_pkg::OP_XOR: ex.ctrl.alu_op = isa_pkg::ALU_XOR;
			isa_pkg::OP_SLL: ex.ctrl.alu_op = isa_pkg::ALU_SLL;
			isa_pkg::OP_SRL: ex.ctrl.alu_op = isa_pkg::ALU_SRL;
			isa_pkg::OP_LUI: ex.ctrl.alu_op = isa_pkg::ALU_PASSB;
			default:         ex.ctrl.alu_op = isa_pkg::ALU_ADD;
		endcase
		// R-format ALU ops write rd from rs and rt
		if ((ins.r.opcode != isa_pkg::OP_NOP) && (ins.r.opcode[3] == 1'b0)) begin
			ex.ctrl.reg_write = 1'b1;
			ex.rd = ins.r.rd;
			ex.rs = ins.r.rs;
			ex.rt = ins.r.rt;
		end
		case (ins.r.opcode)
			isa_pkg::OP_ADDI: begin
				ex.ctrl.reg_write = 1'b1;
				ex.ctrl.src_b = pipe_pkg::SRC_SIMM8;
				ra = ins.i.rd;
				ex.rd = ins.i.rd;
				ex.rs = ins.i.rd;
			end
			isa_pkg::OP_LUI: begin
				ex.ctrl.reg_write = 1'b1;
				ex.ctrl.src_b = pipe_pkg::SRC_ZIMM8_HI;
				ra = ins.i.rd;
				ex.rd = ins.i.rd;
			end
			isa_pkg::OP_LW: begin
				ex.ctrl.reg_write  = 1'b1;
				ex.ctrl.mem_to_reg = 1'b1;
				ex.ctrl.mem_read   = 1'b1;
				ex.ctrl.src_b = pipe_pkg::SRC_SIMM4;
				ex.rd = ins.r.rd;
				ex.rs = ins.r.rs;
			end
			// Store data is the rd register
			isa_pkg::OP_SW: begin
				ex.ctrl.mem_write = 1'b1;
				ex.ctrl.src_b = pipe_pkg::SRC_SIMM4;
				rb = ins.r.rd;
				ex.rs = ins.r.rs;
				ex.rt = ins.r.rd;
			end
			isa_pkg::OP_B: begin
				ex.ctrl.is_branch = 1'b1;
				ra = ins.i.rd;
			end
			isa_pkg::OP_BEQZ, isa_pkg::OP_BNEZ: begin
				ex.ctrl.is_branch = 1'b1;
				ex.ctrl.br_cond = (ins.r.opcode == isa_pkg::OP_BEQZ) ?
					pipe_pkg::BR_EQZ : pipe_pkg::BR_NEZ;
				ra = ins.i.rd;
				ex.rs = ins.i.rd;
			end
			isa_pkg::OP_JR: begin
				ex.ctrl.is_jump = 1'b1;
				ex.rs = ins.r.rs;
			end
			default: begin
			end
		endcase
		va = reg_read(ra, w);
		vb = reg_read(rb, w);
		ex.alu_a    = va;
		ex.mem_data = vb;
		case (ex.ctrl.src_b)
			pipe_pkg::SRC_SIMM8:    ex.alu_b = s8;
			pipe_pkg::SRC_ZIMM8_HI: ex.alu_b = {ins.i.imm8, 8'h00};
			pipe_pkg::SRC_SIMM4:    ex.alu_b = s4;
			default:                ex.alu_b = vb;
		endcase
		// Redirect and target
		br.is_branch = ex.ctrl.is_branch;
		br.is_jump   = ex.ctrl.is_jump;
		br.target    = ex.ctrl.is_jump ? va : (pc + s8);
		case (ins.r.opcode)
			isa_pkg::OP_B:    br.redirect = 1'b1;
			isa_pkg::OP_BEQZ: br.redirect = (va == '0);
			isa_pkg::OP_BNEZ: br.redirect = (va != '0);
			isa_pkg::OP_JR:   br.redirect = 1'b1;
			default:          br.redirect = 1'b0;
		endcase
	endfunction

	////////////////////////////////
	// Checks
	////////////////////////////////

	task automatic check_id_ex(input pipe_pkg::id_ex_t got, input pipe_pkg::id_ex_t exp,
			input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// Target only matters for branches and jumps
	task automatic check_branch(input pipe_pkg::branch_t got, input pipe_pkg::branch_t exp,
			input string what);
		logic tgt_bad;
		checks++;
		tgt_bad = (exp.is_branch || exp.is_jump) && (got.target !== exp.target);
		if ((got.redirect !== exp.redirect) || (got.is_branch !== exp.is_branch) ||
				(got.is_jump !== exp.is_jump) || tgt_bad) begin
			errors++;
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// Compare at the falling edge while inputs are steady
	initial begin
		pipe_pkg::id_ex_t  exp_d;
		pipe_pkg::branch_t exp_br;
		exp_q = '0;
		for (int i = 0; i < `NREGS; i++)
			shadow[i] = '0;
		forever begin
			@(negedge clk_i);
			if (arst_n_i) begin
				check_id_ex(id_ex, exp_q, "id_ex_o");
				ref_decode(instr, pcplus1, wb, exp_d, exp_br);
				check_branch(branch, exp_br, "branch_o");
				// Next edge loads a bubble on flush, else holds on stall
				if (flush)
					exp_q = '0;
				else if (!stall)
					exp_q = exp_d;
				if (wb.we && (wb.addr != '0))
					shadow[wb.addr] = wb.data;
			end
		end
	end

	initial begin
		while (cycles <= CYCLE_LIMIT) begin
			@(posedge clk_i);
			cycles++;
		end
		$display("Timeout: run did not end within %0d cycles", CYCLE_LIMIT);
		$display("Simulation failed");
		$finish;
	end

	////////////////////////////////
	// Tests
	////////////////////////////////

	// Idle cycles so the last instruction gets compared
	task automatic finish_test(input string name, input int start);
		for (int i = 0; i < SETTLE; i++)
			apply_inputs(make_instr(4'h0), '0, 1'b0, 1'b0, make_wb(1'b0, '0, '0));
		tests++;
		$display("Test %0d %s done, %0d errors", tests, name, errors - start);
	endtask

	task automatic test_register_read();
		int          start;
		logic [31:0] r;
		start = errors;
		@(negedge clk_i);
		checks++;
		if (id_ex.valid !== 1'b0) begin
			errors++;
			$display("FAIL %0t: id_ex_o.valid high after reset", $time);
		end
		// Fill every register including r0
		for (int i = 0; i < N_WRITE; i++) begin
			r = next_rand();
			apply_inputs(make_instr(4'h0), r[31:16], 1'b0, 1'b0,
				make_wb(1'b1, `REG_AW'(i), r[15:0]));
		end
		for (int i = 0; i < N_RREAD; i++) begin
			r = next_rand();
			apply_inputs(make_instr({1'b0, r[2:0]}), r[31:16], 1'b0, 1'b0,
				make_wb(1'b0, '0, '0));
		end
		finish_test("register read", start);
	endtask

	// ADDI, LUI, LW, SW
	task automatic test_imm_mem();
		int          start;
		logic [31:0] r;
		start = errors;
		for (int i = 0; i < N_MEM; i++) begin
			r = next_rand();
			apply_inputs(make_instr({2'b10, r[1:0]}), r[23:8], 1'b0, 1'b0,
				make_wb(r[2], r[7:4], r[31:16]));
		end
		finish_test("immediate and memory", start);
	endtask

	// Half the writes clear the tested register so BEQZ takes
	task automatic test_branches();
		int              start;
		logic [31:0]     r;
		isa_pkg::instr_u ins;
		start = errors;
		for (int i = 0; i < N_BRANCH; i++) begin
			r = next_rand();
			ins = make_instr({2'b11, r[1:0]});
			apply_inputs(ins, r[27:12], 1'b0, 1'b0,
				make_wb(r[2], r[3] ? ins.i.rd : r[7:4], r[3] ? '0 : r[31:16]));
		end
		finish_test("branch and jump", start);
	endtask

	task automatic test_stall_flush();
		int          start;
		logic [31:0] r;
		logic        st;
		logic        fl;
		start = errors;
		for (int i = 0; i < N_STALL; i++) begin
			r = next_rand();
			st = ((i % 16) < 10) ? 1'b1 : r[0];
			// Slot 7 always flushes under stall
			fl = ((i % 16) == 7) || (r[6:4] == 3'd0);
			apply_inputs(make_instr(r[11:8]), r[27:12], st, fl,
				make_wb(r[1], r[15:12], r[31:16]));
		end
		finish_test("stall and flush", start);
	endtask

	task automatic test_write_through();
		int                 start;
		logic [31:0]        r;
		logic [`REG_AW-1:0] addr;
		isa_pkg::instr_u    ins;
		start = errors;
		for (int i = 0; i < N_FWD; i++) begin
			r = next_rand();
			addr = (r[6:4] == 3'd0) ? '0 : r[3:0];
			ins = make_instr(4'h1);
			if (r[7])
				ins.r.rs = addr;
			else
				ins.r.rt = addr;
			apply_inputs(ins, r[27:12], 1'b0, 1'b0, make_wb(1'b1, addr, r[31:16]));
		end
		finish_test("write-through", start);
	endtask

	initial begin
		arst_n_i = 1'b0;
		instr    = '0;
		pcplus1  = '0;
		stall    = 1'b0;
		flush    = 1'b0;
		wb       = '0;
		rng      = 32'h94a2;
		repeat (RESET_CYCLES) @(posedge clk_i);
		arst_n_i <= 1'b1;
		test_register_read();
		test_imm_mem();
		test_branches();
		test_stall_flush();
		test_write_through();
		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- list.f
+incdir+include
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/id_decoder.sv
hw/id_reg_file.sv
hw/id_operand_sel.sv
hw/id_branch_unit.sv
hw/id_ex_reg.sv
hw/id_stage.sv
test/tb_id_stage.sv

//--- Bender.yml
package:
  name: id_stage

sources:
  - include_dirs:
      - include
    files:
      - hw/isa_pkg.sv
      - hw/pipe_pkg.sv
      - hw/id_decoder.sv
      - hw/id_reg_file.sv
      - hw/id_operand_sel.sv
      - hw/id_branch_unit.sv
      - hw/id_ex_reg.sv
      - hw/id_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_id_stage.sv
